// ==== files.f ====
+incdir+.
iigs_bus_pkg.sv
iigs_disk_pkg.sv
bus_phase_ctrl.sv
mem_map_decode.sv
slow_ram.sv
hdd_slot.sv
iigs_mem_top.sv
tb_iigs_mem.sv

// ==== Bender.yml ====
package:
  name: iigs_mem

sources:
  - include_dirs:
      - .
    files:
      - iigs_bus_pkg.sv
      - iigs_disk_pkg.sv
      - bus_phase_ctrl.sv
      - mem_map_decode.sv
      - slow_ram.sv
      - hdd_slot.sv
      - iigs_mem_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_iigs_mem.sv

// ==== tb_iigs_mem.sv ====
`timescale 1ns/1ps
`include "iigs_defines.svh"

module tb_iigs_mem
  import iigs_bus_pkg::*;
  import iigs_disk_pkg::*;
();

  localparam int WAIT_LIMIT = 4 * `IIGS_BUS_PHASES;

  logic        clk_sys;
  logic        rst_n;
  logic [7:0]  bank;
  logic [15:0] addr;
  logic        cpu_we;
  logic [7:0]  cpu_wdata;
  logic [7:0]  cpu_rdata;
  logic        io_space;
  logic [7:0]  shadow;
  logic [7:0]  sltromsel;
  logic        rdrom;
  logic        lc_we;
  logic        cxrom;
  logic        phase_strobe;
  logic [15:0] rom_addr;
  rom_sel_e    rom_sel;
  logic [7:0]  rom_rdata = 8'h00;
  logic [22:0] fast_addr;
  logic [7:0]  fast_wdata;
  logic [7:0]  fast_rdata = 8'h00;
  logic        fast_we;
  logic        fast_ce;
  logic [16:0] video_addr;
  logic [7:0]  video_data;
  logic [15:0] hdd_sector;
  logic        hdd_read;
  logic        hdd_write;
  logic        hdd_done;
  logic        hdd_mounted;
  logic        hdd_protect;
  logic [8:0]  hdd_ram_addr;
  logic [7:0]  hdd_ram_wdata;
  logic        hdd_ram_we;
  logic [7:0]  hdd_ram_rdata;

  // fast_mem is the external part that the DUT writes and the *_exp arrays hold the reference
  logic [7:0]  fast_mem [logic [22:0]];
  logic [7:0]  fast_exp [logic [22:0]];
  logic [7:0]  slow_exp [logic [16:0]];
  logic [7:0]  disk_buf [0:511];
  logic [16:0] video_q [$];
  logic [7:0]  wr_bank_q [$];
  logic [15:0] wr_addr_q [$];
  int          errors;
  int          bus_cycles;
  int          strobe_steps;
  logic        strobe_fast_we;
  logic        strobe_fast_ce;
  logic [22:0] strobe_fast_addr;
  logic [7:0]  strobe_fast_wdata;

  iigs_mem_top DUT (.*);

  initial
  begin
    clk_sys = 1'b0;
    forever #20 clk_sys = ~clk_sys;
  end

  // every ROM image byte is a hash of the image and the address
  function automatic logic [7:0] rom_byte(rom_sel_e sel, logic [15:0] a);
    return a[7:0] ^ {a[14:8], a[15]} ^ (8'h3C + 8'(sel) * 8'h51);
  endfunction

  // unwritten fast RAM reads back a pattern of the whole 23-bit address
  function automatic logic [7:0] fill_byte(logic [22:0] a);
    return a[7:0] ^ a[15:8] ^ {1'b1, a[22:16]};
  endfunction

  function automatic logic in_range(logic [15:0] a, logic [15:0] lo, logic [15:0] hi);
    return (a >= lo) && (a <= hi);
  endfunction

  // reference memory map walked in priority order like the CPU sees it
  function automatic void ref_decode(input logic [7:0] b, input logic [15:0] a,
                                     output mem_region_e rgn, output rom_sel_e sel,
                                     output logic fast_w, output logic slow_w);
    logic io_b;
    logic lo_b;
    logic aux;
    logic disk;
    logic rom2;
    logic fast;
    logic shd;
    logic slow;
    io_b = (b == 8'h00) || (b == 8'h01) || (b == 8'hE0) || (b == 8'hE1);
    lo_b = (b == 8'h00) || (b == 8'h01);
    aux  = (b != 8'h01) || !shadow[4];
    disk = io_b && in_range(a, 16'hC0F0, 16'hC0FF) && sltromsel[7];
    rom2 = (b == `IIGS_ROM2_BANK) || ((b == 8'h00) && (a >= 16'hC000) && rdrom);
    fast = (b < `IIGS_FAST_BANKS) && !io_space &&
           (!rom2 || ((b == 8'h00) && in_range(a, 16'hD000, 16'hDFFF) && lc_we));
    shd  = (shadow[6] && (a >= 16'hC000)) ||
           (aux && !shadow[0] && in_range(a, 16'h0400, 16'h07FF)) ||
           (aux && !shadow[5] && in_range(a, 16'h0800, 16'h0BFF)) ||
           (((aux && !shadow[1]) || !shadow[3]) && in_range(a, 16'h2000, 16'h3FFF)) ||
           (((aux && !shadow[2]) || !shadow[3]) && in_range(a, 16'h4000, 16'h5FFF));
    slow = (b == 8'hE0) || (b == 8'hE1) || (!io_space && lo_b && shd);
    fast_w = fast && !disk;
    slow_w = slow && !disk;
    sel = ROM_SEL_SYS;
    if (disk)
      rgn = REG_DISK;
    else if (b == `IIGS_ROM1_BANK)
    begin
      rgn = REG_ROM1;
      sel = ROM_SEL_FE;
    end
    else if (rom2)
      rgn = REG_ROM2;
    else if (fast)
      rgn = REG_FAST;
    else if (io_b && in_range(a, 16'hC100, 16'hC7FF) && !sltromsel[a[10:8]])
      rgn = REG_SLOT_ROM;
    else if (io_b && in_range(a, 16'hC700, 16'hC7FF) && sltromsel[7] && !cxrom)
    begin
      rgn = REG_SLOT_ROM;
      sel = ROM_SEL_SLOT7;
    end
    else if (slow)
      rgn = REG_SLOW;
    else
      rgn = REG_NONE;
  endfunction

  function automatic logic [7:0] expected_read(logic [7:0] b, logic [15:0] a);
    mem_region_e rgn;
    rom_sel_e    sel;
    logic        fw;
    logic        sw;
    ref_decode(b, a, rgn, sel, fw, sw);
    case (rgn)
      REG_ROM1, REG_ROM2, REG_SLOT_ROM: return rom_byte(sel, a);
      REG_FAST: return fast_exp.exists({b[6:0], a}) ? fast_exp[{b[6:0], a}] :
                                                     fill_byte({b[6:0], a});
      REG_SLOW: return slow_exp[{b[0], a}];
      default:  return `IIGS_FLOAT_DATA;
    endcase
  endfunction

  // external ROM and fast RAM answer one clock after the address as the internal memories do
  always @(posedge clk_sys)
  begin
    rom_rdata <= rom_byte(rom_sel, rom_addr);
    if (fast_mem.exists(fast_addr))
      fast_rdata <= fast_mem[fast_addr];
    else
      fast_rdata <= fill_byte(fast_addr);
    if (fast_we)
      fast_mem[fast_addr] = fast_wdata;
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp_v);
    errors++;
    $display("MISMATCH %s got %h expected %h at %0t", name, got, exp_v, $time);
  endtask

  task automatic timeout_fail(input string what);
    $display("timeout while waiting for %s, errors so far %0d", what, errors);
    $display("CHECKS FAILED");
    $finish;
  endtask

  // inputs always change 2 ns after a rising edge
  task automatic step();
    @(posedge clk_sys);
    #2;
  endtask

  task automatic wait_strobe();
    int n;
    n = 0;
    while (!phase_strobe && (n < WAIT_LIMIT))
    begin
      step();
      n++;
    end
    strobe_steps = n;
    if (!phase_strobe)
      timeout_fail("phase_strobe");
  endtask

  // leaves the bus at phase 1 right after the strobe edge
  task automatic align_bus();
    wait_strobe();
    step();
  endtask

  task automatic wait_hdd(input logic want_read, input logic level);
    int n;
    n = 0;
    while (((want_read ? hdd_read : hdd_write) !== level) && (n < WAIT_LIMIT))
    begin
      step();
      n++;
    end
    if ((want_read ? hdd_read : hdd_write) !== level)
      timeout_fail(want_read ? "hdd_read" : "hdd_write");
  endtask

  // one CPU bus cycle holds the request from phase 1 through the next strobe edge
  task automatic bus_cycle(input logic [7:0] b, input logic [15:0] a, input logic we,
                           input logic [7:0] wd, output logic [7:0] rd);
    bank      = b;
    addr      = a;
    cpu_we    = we;
    cpu_wdata = wd;
    wait_strobe();
    // every bus cycle starts at phase 1, so the strobe is the last of the phases
    if (strobe_steps != `IIGS_BUS_PHASES - 1)
      report_mismatch("phase_strobe period", strobe_steps, `IIGS_BUS_PHASES - 1);
    strobe_fast_we    = fast_we;
    strobe_fast_ce    = fast_ce;
    strobe_fast_addr  = fast_addr;
    strobe_fast_wdata = fast_wdata;
    step();
    rd     = cpu_rdata;
    cpu_we = 1'b0;
    bus_cycles++;
  endtask

  task automatic do_write(input logic [7:0] b, input logic [15:0] a, input logic [7:0] wd);
    mem_region_e rgn;
    rom_sel_e    sel;
    logic        fw;
    logic        sw;
    logic [7:0]  rd_unused;
    ref_decode(b, a, rgn, sel, fw, sw);
    bus_cycle(b, a, 1'b1, wd, rd_unused);
    if (strobe_fast_we !== fw)
      report_mismatch("fast_we", strobe_fast_we, fw);
    if (strobe_fast_ce !== fw)
      report_mismatch("fast_ce", strobe_fast_ce, fw);
    if (fw && (strobe_fast_addr !== {b[6:0], a}))
      report_mismatch("fast_addr", strobe_fast_addr, {b[6:0], a});
    if (fw && (strobe_fast_wdata !== wd))
      report_mismatch("fast_wdata", strobe_fast_wdata, wd);
    if (fw)
      fast_exp[{b[6:0], a}] = wd;
    if (sw)
      slow_exp[{b[0], a}] = wd;
  endtask

  // slow RAM powers up unknown, so a location gets a known byte through E0/E1 first
  task automatic ensure_slow(input logic [16:0] sa);
    if (!slow_exp.exists(sa))
      do_write({7'b1110000, sa[16]}, sa[15:0], 8'($urandom));
  endtask

  task automatic check_read(input logic [7:0] b, input logic [15:0] a);
    mem_region_e rgn;
    rom_sel_e    sel;
    logic        fw;
    logic        sw;
    logic [7:0]  exp_v;
    logic [7:0]  got;
    ref_decode(b, a, rgn, sel, fw, sw);
    if (rgn == REG_SLOW)
      ensure_slow({b[0], a});
    exp_v = expected_read(b, a);
    bus_cycle(b, a, 1'b0, 8'h00, got);
    if (got !== exp_v)
      report_mismatch("cpu_rdata", got, exp_v);
    if (strobe_fast_ce !== fw)
      report_mismatch("fast_ce", strobe_fast_ce, fw);
  endtask

  // the disk card registers sit at C0F0 to C0FF of bank E0
  task automatic disk_reg_write(input logic [3:0] r, input logic [7:0] v);
    do_write(8'hE0, {12'hC0F, r}, v);
  endtask

  task automatic disk_reg_read(input logic [3:0] r, output logic [7:0] v);
    bus_cycle(8'hE0, {12'hC0F, r}, 1'b0, 8'h00, v);
  endtask

  // moves the bus off the data port so no strobe advances the pointer
  task automatic park_bus();
    bank   = `IIGS_ROM2_BANK;
    addr   = 16'h0000;
    cpu_we = 1'b0;
  endtask

  initial
  begin
    int          seed_v;
    logic [7:0]  b_v;
    logic [7:0]  wd_v;
    logic [7:0]  got_v;
    logic [15:0] a_v;
    logic [15:0] sector_v;
    logic [16:0] sa_v;
    seed_v = $urandom(52793);
    errors = 0;
    bus_cycles = 0;
    strobe_steps = 0;
    rst_n = 1'b0;
    bank = `IIGS_ROM2_BANK;
    addr = 16'h0000;
    cpu_we = 1'b0;
    cpu_wdata = 8'h00;
    io_space = 1'b0;
    shadow = 8'hFF;
    sltromsel = 8'h00;
    rdrom = 1'b0;
    lc_we = 1'b0;
    cxrom = 1'b0;
    video_addr = 17'h0;
    hdd_done = 1'b0;
    hdd_mounted = 1'b1;
    hdd_protect = 1'b0;
    hdd_ram_addr = 9'h0;
    hdd_ram_wdata = 8'h00;
    hdd_ram_we = 1'b0;
    repeat (4) @(posedge clk_sys);
    #2;
    rst_n = 1'b1;

    // bank FF keeps fast RAM deselected while the reset values are checked
    if (cpu_rdata !== 8'h00)
      report_mismatch("cpu_rdata", cpu_rdata, 8'h00);
    if (fast_we !== 1'b0)
      report_mismatch("fast_we", fast_we, 1'b0);
    if (fast_ce !== 1'b0)
      report_mismatch("fast_ce", fast_ce, 1'b0);
    if (hdd_read !== 1'b0)
      report_mismatch("hdd_read", hdd_read, 1'b0);
    if (hdd_write !== 1'b0)
      report_mismatch("hdd_write", hdd_write, 1'b0);
    align_bus();

    // random reads over the whole map with banks and addresses biased toward region edges
    repeat (300)
    begin
      io_space  = ($urandom % 4) == 0;
      shadow    = 8'($urandom);
      sltromsel = 8'($urandom);
      rdrom     = 1'($urandom);
      lc_we     = 1'($urandom);
      cxrom     = 1'($urandom);
      case ($urandom % 10)
        0:       b_v = 8'h00;
        1:       b_v = 8'h01;
        2:       b_v = 8'hE0;
        3:       b_v = 8'hE1;
        4:       b_v = `IIGS_ROM1_BANK;
        5:       b_v = `IIGS_ROM2_BANK;
        6:       b_v = 8'($urandom % 32'd20);
        7:       b_v = 8'h14;
        default: b_v = 8'($urandom);
      endcase
      case ($urandom % 6)
        0:       a_v = 16'hC000 + 16'($urandom % 32'h800);
        1:       a_v = 16'hD000 + 16'($urandom % 32'h1000);
        2:       a_v = 16'h0400 + 16'($urandom % 32'h800);
        3:       a_v = 16'h2000 + 16'($urandom % 32'h4000);
        4:       a_v = 16'hC700 + 16'($urandom % 32'h100);
        default: a_v = 16'($urandom);
      endcase
      if (a_v[15:4] == 12'hC0F)
        sltromsel[7] = 1'b0;
      check_read(b_v, a_v);
    end

    // fast RAM writes with plain switches, then read back
    io_space  = 1'b0;
    sltromsel = 8'h00;
    rdrom     = 1'b0;
    lc_we     = 1'b0;
    cxrom     = 1'b0;
    shadow    = 8'hFF;
    repeat (40)
    begin
      b_v = 8'($urandom % 32'd20);
      a_v = 16'($urandom);
      wr_bank_q.push_back(b_v);
      wr_addr_q.push_back(a_v);
      do_write(b_v, a_v, 8'($urandom));
    end
    while (wr_bank_q.size() > 0)
      check_read(wr_bank_q.pop_front(), wr_addr_q.pop_front());

    // language card write-through goes to RAM while reads still come from ROM2
    repeat (8)
    begin
      a_v   = 16'hD000 + 16'($urandom % 32'h1000);
      rdrom = 1'b1;
      lc_we = 1'b1;
      do_write(8'h00, a_v, 8'($urandom));
      check_read(8'h00, a_v);
      rdrom = 1'b0;
      check_read(8'h00, a_v);
    end
    lc_we = 1'b0;

    // each slow location is seeded before a shadowed or E0/E1 write so an unshadowed write shows
    repeat (40)
    begin
      shadow = 8'($urandom);
      case ($urandom % 4)
        0:       b_v = 8'h00;
        1:       b_v = 8'h01;
        2:       b_v = 8'hE0;
        default: b_v = 8'hE1;
      endcase
      case ($urandom % 4)
        0:       a_v = 16'h0400 + 16'($urandom % 32'h800);
        1:       a_v = 16'h2000 + 16'($urandom % 32'h4000);
        2:       a_v = 16'hC000 + 16'($urandom % 32'h4000);
        default: a_v = 16'($urandom);
      endcase
      ensure_slow({b_v[0], a_v});
      do_write(b_v, a_v, 8'($urandom));
      video_q.push_back({b_v[0], a_v});
    end
    while (video_q.size() > 0)
    begin
      sa_v = video_q.pop_front();
      video_addr = sa_v;
      step();
      if (video_data !== slow_exp[sa_v])
        report_mismatch("video_data", video_data, slow_exp[sa_v]);
    end
    align_bus();

    // the host fills the sector buffer after a disk read command
    sltromsel = 8'h80;
    sector_v  = 16'($urandom);
    disk_reg_write(4'h2, sector_v[7:0]);
    disk_reg_write(4'h3, sector_v[15:8]);
    disk_reg_write(4'h0, DCMD_READ);
    wait_hdd(1'b1, 1'b1);
    if (hdd_sector !== sector_v)
      report_mismatch("hdd_sector", hdd_sector, sector_v);
    disk_reg_read(4'h0, got_v);
    if (got_v !== 8'h81)
      report_mismatch("disk status", got_v, 8'h81);
    for (int i = 0; i < 512; i++)
    begin
      hdd_ram_addr  = 9'(i);
      hdd_ram_wdata = 8'($urandom);
      hdd_ram_we    = 1'b1;
      disk_buf[i]   = hdd_ram_wdata;
      step();
    end
    hdd_ram_we = 1'b0;
    hdd_done   = 1'b1;
    step();
    hdd_done = 1'b0;
    wait_hdd(1'b1, 1'b0);
    align_bus();
    disk_reg_write(4'h1, 8'h00);
    for (int i = 0; i < 512; i++)
    begin
      disk_reg_read(4'h8, got_v);
      if (got_v !== disk_buf[i])
        report_mismatch("disk data port", got_v, disk_buf[i]);
    end
    park_bus();

    // the host reads the buffer back after a disk write command
    disk_reg_write(4'h1, 8'h00);
    for (int i = 0; i < 512; i++)
    begin
      wd_v = 8'($urandom);
      disk_buf[i] = wd_v;
      disk_reg_write(4'h8, wd_v);
    end
    disk_reg_write(4'h0, DCMD_WRITE);
    wait_hdd(1'b0, 1'b1);
    park_bus();
    for (int i = 0; i < 512; i++)
    begin
      hdd_ram_addr = 9'(i);
      step();
      if (hdd_ram_rdata !== disk_buf[i])
        report_mismatch("hdd_ram_rdata", hdd_ram_rdata, disk_buf[i]);
    end
    hdd_done = 1'b1;
    step();
    hdd_done = 1'b0;
    wait_hdd(1'b0, 1'b0);

    // with write protect the same command must not start a transfer
    // the volume is unmounted here so both status bits show the other value
    hdd_protect = 1'b1;
    hdd_mounted = 1'b0;
    align_bus();
    disk_reg_write(4'h0, DCMD_WRITE);
    disk_reg_read(4'h0, got_v);
    if (got_v !== 8'h02)
      report_mismatch("disk status", got_v, 8'h02);
    if (hdd_write !== 1'b0)
      report_mismatch("hdd_write", hdd_write, 1'b0);
    hdd_protect = 1'b0;
    hdd_mounted = 1'b1;

    $display("bus cycles %0d, errors %0d", bus_cycles, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== iigs_mem_top.sv ====
`timescale 1ns/1ps

module iigs_mem_top
  import iigs_bus_pkg::*;
(
  input  logic        clk_sys,
  input  logic        rst_n,
  input  logic [7:0]  bank,
  input  logic [15:0] addr,
  input  logic        cpu_we,
  input  logic [7:0]  cpu_wdata,
  output logic [7:0]  cpu_rdata,
  input  logic        io_space,
  input  logic [7:0]  shadow,
  input  logic [7:0]  sltromsel,
  input  logic        rdrom,
  input  logic        lc_we,
  input  logic        cxrom,
  output logic        phase_strobe,
  output logic [15:0] rom_addr,
  output rom_sel_e    rom_sel,
  input  logic [7:0]  rom_rdata,
  output logic [22:0] fast_addr,
  output logic [7:0]  fast_wdata,
  input  logic [7:0]  fast_rdata,
  output logic        fast_we,
  output logic        fast_ce,
  input  logic [16:0] video_addr,
  output logic [7:0]  video_data,
  output logic [15:0] hdd_sector,
  output logic        hdd_read,
  output logic        hdd_write,
  input  logic        hdd_done,
  input  logic        hdd_mounted,
  input  logic        hdd_protect,
  input  logic [8:0]  hdd_ram_addr,
  input  logic [7:0]  hdd_ram_wdata,
  input  logic        hdd_ram_we,
  output logic [7:0]  hdd_ram_rdata
);

  mem_region_e region;
  logic        disk_sel;
  logic        fast_sel;
  logic        slow_sel;
  logic        bus_wr;
  logic [7:0]  slow_rdata;
  logic [7:0]  disk_rdata;

  // one write pulse per bus cycle, each target adds its own select
  assign bus_wr = cpu_we & phase_strobe;

  // external ROM and fast RAM are addressed straight from the CPU bus
  assign rom_addr   = addr;
  assign fast_addr  = {bank[6:0], addr};
  assign fast_wdata = cpu_wdata;
  assign fast_ce    = fast_sel;
  assign fast_we    = bus_wr & fast_sel;

  bus_phase_ctrl u_phase (
    .clk_sys      (clk_sys),
    .rst_n        (rst_n),
    .region       (region),
    .rom_rdata    (rom_rdata),
    .fast_rdata   (fast_rdata),
    .slow_rdata   (slow_rdata),
    .disk_rdata   (disk_rdata),
    .phase_strobe (phase_strobe),
    .cpu_rdata    (cpu_rdata)
  );

  mem_map_decode u_decode (
    .bank      (bank),
    .addr      (addr),
    .io_space  (io_space),
    .shadow    (shadow),
    .sltromsel (sltromsel),
    .rdrom     (rdrom),
    .lc_we     (lc_we),
    .cxrom     (cxrom),
    .region    (region),
    .rom_sel   (rom_sel),
    .disk_sel  (disk_sel),
    .fast_sel  (fast_sel),
    .slow_sel  (slow_sel)
  );

  // bank bit 0 picks E0 or E1, shadowed banks 00/01 map the same way
  slow_ram u_slow (
    .clk_sys    (clk_sys),
    .cpu_addr   ({bank[0], addr}),
    .cpu_wdata  (cpu_wdata),
    .cpu_we     (bus_wr & slow_sel),
    .cpu_rdata  (slow_rdata),
    .video_addr (video_addr),
    .video_data (video_data)
  );

  hdd_slot u_hdd (
    .clk_sys       (clk_sys),
    .rst_n         (rst_n),
    .sel           (disk_sel),
    .reg_addr      (addr[3:0]),
    .cpu_we        (bus_wr),
    .phase_strobe  (phase_strobe),
    .cpu_wdata     (cpu_wdata),
    .rdata         (disk_rdata),
    .hdd_sector    (hdd_sector),
    .hdd_read      (hdd_read),
    .hdd_write     (hdd_write),
    .hdd_done      (hdd_done),
    .hdd_mounted   (hdd_mounted),
    .hdd_protect   (hdd_protect),
    .hdd_ram_addr  (hdd_ram_addr),
    .hdd_ram_wdata (hdd_ram_wdata),
    .hdd_ram_we    (hdd_ram_we),
    .hdd_ram_rdata (hdd_ram_rdata)
  );

endmodule

// ==== hdd_slot.sv ====
`timescale 1ns/1ps

module hdd_slot
  import iigs_disk_pkg::*;
(
  input  logic        clk_sys,
  input  logic        rst_n,
  input  logic        sel,
  input  logic [3:0]  reg_addr,
  input  logic        cpu_we,
  input  logic        phase_strobe,
  input  logic [7:0]  cpu_wdata,
  output logic [7:0]  rdata,
  output logic [15:0] hdd_sector,
  output logic        hdd_read,
  output logic        hdd_write,
  input  logic        hdd_done,
  input  logic        hdd_mounted,
  input  logic        hdd_protect,
  input  logic [8:0]  hdd_ram_addr,
  input  logic [7:0]  hdd_ram_wdata,
  input  logic        hdd_ram_we,
  output logic [7:0]  hdd_ram_rdata
);

  localparam logic [3:0] ADDR_CMD    = 4'h0;
  localparam logic [3:0] ADDR_PTR    = 4'h1;
  localparam logic [3:0] ADDR_SEC_LO = 4'h2;
  localparam logic [3:0] ADDR_SEC_HI = 4'h3;
  localparam logic [3:0] ADDR_DATA   = 4'h8;

  disk_state_e state;
  disk_cmd_e   cmd;
  logic [8:0]  ptr;
  logic [7:0]  sector_buf [0:511];
  logic [7:0]  status;
  logic        wr_cmd;
  logic        data_wr;
  logic        data_rd;

  // cpu_we arrives already qualified by the phase strobe
  assign wr_cmd  = sel && cpu_we && (reg_addr == ADDR_CMD);
  assign data_wr = sel && cpu_we && (reg_addr == ADDR_DATA);
  // a read completes on the strobe edge that ends the bus cycle
  assign data_rd = sel && phase_strobe && !cpu_we && (reg_addr == ADDR_DATA);

  assign cmd    = disk_cmd_e'(cpu_wdata);
  assign status = {(state != DISK_IDLE), 5'b00000, hdd_protect, hdd_mounted};

  // commands are only taken in idle and a pending transfer drops them
  always_ff @(posedge clk_sys or negedge rst_n)
  begin
    if (!rst_n)
      state <= DISK_IDLE;
    else
    begin
      case (state)
        DISK_IDLE:
        begin
          if (wr_cmd && (cmd == DCMD_READ))
            state <= DISK_READING;
          else if (wr_cmd && (cmd == DCMD_WRITE) && !hdd_protect)
            state <= DISK_WRITING;
        end
        DISK_READING, DISK_WRITING:
        begin
          if (hdd_done)
            state <= DISK_IDLE;
        end
        default:
          state <= DISK_IDLE;
      endcase
    end
  end

  // the host watches these two levels to know which way to move data
  assign hdd_read  = (state == DISK_READING);
  assign hdd_write = (state == DISK_WRITING);

  // sector number and the buffer pointer seen through the data port
  always_ff @(posedge clk_sys or negedge rst_n)
  begin
    if (!rst_n)
    begin
      hdd_sector <= 16'h0000;
      ptr        <= 9'd0;
    end
    else
    begin
      if (sel && cpu_we && (reg_addr == ADDR_SEC_LO))
        hdd_sector[7:0] <= cpu_wdata;
      if (sel && cpu_we && (reg_addr == ADDR_SEC_HI))
        hdd_sector[15:8] <= cpu_wdata;
      // pointer wraps naturally at 512
      if (sel && cpu_we && (reg_addr == ADDR_PTR))
        ptr <= 9'd0;
      else if (data_wr || data_rd)
        ptr <= ptr + 9'd1;
    end
  end

  // the host fills the sector buffer during a read command
  // and the CPU fills it through the data port before a write
  always_ff @(posedge clk_sys)
  begin
    if (hdd_ram_we)
      sector_buf[hdd_ram_addr] <= hdd_ram_wdata;
    else if (data_wr)
      sector_buf[ptr] <= cpu_wdata;
    hdd_ram_rdata <= sector_buf[hdd_ram_addr];
  end

  // register reads answer one clock after the address
  always_ff @(posedge clk_sys)
  begin
    case (reg_addr)
      ADDR_CMD:    rdata <= status;
      ADDR_SEC_LO: rdata <= hdd_sector[7:0];
      ADDR_SEC_HI: rdata <= hdd_sector[15:8];
      ADDR_DATA:   rdata <= sector_buf[ptr];
      default:     rdata <= 8'h00;
    endcase
  end

  one_transfer_dir: assert property (@(posedge clk_sys) disable iff (!rst_n)
    !(hdd_read && hdd_write));

endmodule

// ==== slow_ram.sv ====
`timescale 1ns/1ps

module slow_ram
(
  input  logic        clk_sys,
  input  logic [16:0] cpu_addr,
  input  logic [7:0]  cpu_wdata,
  input  logic        cpu_we,
  output logic [7:0]  cpu_rdata,
  input  logic [16:0] video_addr,
  output logic [7:0]  video_data
);

  localparam int DEPTH = 1 << 17;

  // banks E0 and E1 back to back, bank bit 0 selects the half
  logic [7:0] mem [0:DEPTH-1];

  // CPU port, write and read share the address
  // a read during a write returns the previous contents
  always_ff @(posedge clk_sys)
  begin
    if (cpu_we)
      mem[cpu_addr] <= cpu_wdata;
    cpu_rdata <= mem[cpu_addr];
  end

  // video port only reads and runs on the same clock
  always_ff @(posedge clk_sys)
  begin
    video_data <= mem[video_addr];
  end

endmodule

// ==== mem_map_decode.sv ====
`timescale 1ns/1ps
`include "iigs_defines.svh"

module mem_map_decode
  import iigs_bus_pkg::*;
(
  input  logic [7:0]  bank,
  input  logic [15:0] addr,
  input  logic        io_space,
  input  logic [7:0]  shadow,
  input  logic [7:0]  sltromsel,
  input  logic        rdrom,
  input  logic        lc_we,
  input  logic        cxrom,
  output mem_region_e region,
  output rom_sel_e    rom_sel,
  output logic        disk_sel,
  output logic        fast_sel,
  output logic        slow_sel
);

  logic io_bank;
  logic lo_bank;
  logic aux_ok;
  logic rom1_hit;
  logic rom2_hit;
  logic lc_wthru;
  logic slot_sys_hit;
  logic slot7_hit;
  logic io_shadow_hit;
  logic txt_hit;
  logic alt_hit;
  logic hgr1_hit;
  logic hgr2_hit;

  // banks where the I/O page and the slot space are visible
  assign io_bank = bank inside {8'h00, 8'h01, 8'hE0, 8'hE1};
  assign lo_bank = bank inside {8'h00, 8'h01};

  // in bank 01 the page shadows also need the aux shadow bit 4 clear
  assign aux_ok = (bank != 8'h01) || !shadow[4];

  // slot-7 device registers, only when slot 7 is switched to the card
  assign disk_sel = io_bank && (addr[15:4] == 12'hC0F) && sltromsel[7];

  assign rom1_hit = (bank == `IIGS_ROM1_BANK);
  assign rom2_hit = (bank == `IIGS_ROM2_BANK) ||
                    ((bank == 8'h00) && (addr >= 16'hC000) && rdrom);

  // language card write-through, ROM answers reads but RAM takes writes
  assign lc_wthru = (bank == 8'h00) && (addr[15:12] == 4'hD) && lc_we;

  // fast RAM select also drives the write path, so it stays true
  // under write-through even though ROM2 wins the read decode
  assign fast_sel = (bank < `IIGS_FAST_BANKS) && !io_space &&
                    (!rom2_hit || lc_wthru) && !disk_sel;

  // internal firmware for any slot whose sltromsel bit is clear
  assign slot_sys_hit = io_bank && (addr >= 16'hC100) && (addr <= 16'hC7FF) &&
                        !sltromsel[addr[10:8]];
  assign slot7_hit = io_bank && (addr[15:8] == 8'hC7) && sltromsel[7] && !cxrom;

  // shadow rules, each one maps a bank 00/01 area onto slow RAM
  assign io_shadow_hit = lo_bank && shadow[6] && (addr >= 16'hC000);
  // text page at 0400 to 07FF
  assign txt_hit = lo_bank && aux_ok && !shadow[0] && (addr[15:10] == 6'b000001);
  // text page 2 at 0800 to 0BFF
  assign alt_hit = lo_bank && aux_ok && !shadow[5] && (addr[15:10] == 6'b000010);
  // hires page 1, super hires bit 3 ignores the aux condition
  assign hgr1_hit = lo_bank && ((aux_ok && !shadow[1]) || !shadow[3]) &&
                    (addr[15:13] == 3'b001);
  // hires page 2, same pairing with bit 3
  assign hgr2_hit = lo_bank && ((aux_ok && !shadow[2]) || !shadow[3]) &&
                    (addr[15:13] == 3'b010);

  // E0/E1 always reach slow RAM, shadowed writes land there as well
  assign slow_sel = !disk_sel &&
                    ((bank == 8'hE0) || (bank == 8'hE1) ||
                     (!io_space && (io_shadow_hit || txt_hit || alt_hit ||
                                    hgr1_hit || hgr2_hit)));

  // read decode in strict priority, exactly one region comes out
  always_comb
  begin
    region  = REG_NONE;
    rom_sel = ROM_SEL_SYS;
    if (disk_sel)
      region = REG_DISK;
    else if (rom1_hit)
    begin
      region  = REG_ROM1;
      rom_sel = ROM_SEL_FE;
    end
    else if (rom2_hit)
      region = REG_ROM2;
    else if (fast_sel)
      region = REG_FAST;
    else if (slot_sys_hit)
      region = REG_SLOT_ROM;
    else if (slot7_hit)
    begin
      region  = REG_SLOT_ROM;
      rom_sel = ROM_SEL_SLOT7;
    end
    else if (slow_sel)
      region = REG_SLOW;
  end

  disk_owns_region: assert final (!disk_sel || (region == REG_DISK));

endmodule

// ==== bus_phase_ctrl.sv ====
`timescale 1ns/1ps
`include "iigs_defines.svh"

module bus_phase_ctrl
  import iigs_bus_pkg::*;
(
  input  logic        clk_sys,
  input  logic        rst_n,
  input  mem_region_e region,
  input  logic [7:0]  rom_rdata,
  input  logic [7:0]  fast_rdata,
  input  logic [7:0]  slow_rdata,
  input  logic [7:0]  disk_rdata,
  output logic        phase_strobe,
  output logic [7:0]  cpu_rdata
);

  localparam int PHASE_W = $clog2(`IIGS_BUS_PHASES);
  localparam logic [PHASE_W-1:0] PHASE_LAST  = PHASE_W'(`IIGS_BUS_PHASES - 1);
  localparam logic [PHASE_W-1:0] PHASE_LATCH = PHASE_W'(2);

  logic [PHASE_W-1:0] phase_cnt;
  logic [7:0]         rdata_mux;

  // free-running phase counter, one full turn per bus cycle
  always_ff @(posedge clk_sys or negedge rst_n)
  begin
    if (!rst_n)
      phase_cnt <= '0;
    else if (phase_cnt == PHASE_LAST)
      phase_cnt <= '0;
    else
      phase_cnt <= phase_cnt + 1'b1;
  end

  // write strobe, all targets commit on the edge that ends phase 0
  assign phase_strobe = (phase_cnt == '0);

  // all ROM flavours share the one external ROM port
  always_comb
  begin
    case (region)
      REG_DISK:     rdata_mux = disk_rdata;
      REG_ROM1:     rdata_mux = rom_rdata;
      REG_ROM2:     rdata_mux = rom_rdata;
      REG_SLOT_ROM: rdata_mux = rom_rdata;
      REG_FAST:     rdata_mux = fast_rdata;
      REG_SLOW:     rdata_mux = slow_rdata;
      default:      rdata_mux = `IIGS_FLOAT_DATA;
    endcase
  end

  // memories answer one clock after the address, so by phase 2 the
  // selected data is settled and can be held for the rest of the cycle
  always_ff @(posedge clk_sys or negedge rst_n)
  begin
    if (!rst_n)
      cpu_rdata <= 8'h00;
    else if (phase_cnt == PHASE_LATCH)
      cpu_rdata <= rdata_mux;
  end

  phase_in_range: assert property (@(posedge clk_sys) disable iff (!rst_n)
    phase_cnt <= PHASE_LAST);

endmodule

// ==== iigs_disk_pkg.sv ====
package iigs_disk_pkg;

  // the controller waits in idle until a command starts a host transfer
  typedef enum logic [1:0] {
    DISK_IDLE,
    DISK_READING,
    DISK_WRITING
  } disk_state_e;

  // command byte written to register 0 of the disk card
  typedef enum logic [7:0] {
    DCMD_NONE  = 8'd0,
    DCMD_READ  = 8'd1,
    DCMD_WRITE = 8'd2
  } disk_cmd_e;

endpackage

// ==== iigs_bus_pkg.sv ====
package iigs_bus_pkg;

  // target of the current CPU access, in order of decode priority
  // REG_DISK covers the slot-7 device registers at C0F0 to C0FF
  // REG_SLOT_ROM is served by the external ROM port, like ROM1 and ROM2
  // REG_NONE makes the read mux return the floating value
  typedef enum logic [2:0] {
    REG_DISK,
    REG_ROM1,
    REG_ROM2,
    REG_FAST,
    REG_SLOT_ROM,
    REG_SLOW,
    REG_NONE
  } mem_region_e;

  // image that the external ROM port reads from
  // the system image also carries the internal slot firmware
  // the slot-7 image is the disk card firmware at C700
  typedef enum logic [1:0] {
    ROM_SEL_FE,
    ROM_SEL_SYS,
    ROM_SEL_SLOT7
  } rom_sel_e;

endpackage

// ==== iigs_defines.svh ====
`ifndef IIGS_DEFINES_SVH
`define IIGS_DEFINES_SVH

// number of clk_sys cycles that make up one CPU bus cycle
// phase 0 commits writes and phase 2 latches read data
`define IIGS_BUS_PHASES 8

// banks 00 up to this value minus one hold fast RAM
// the external fast RAM sees bank bits 6 to 0 as its upper address
`define IIGS_FAST_BANKS 8'd20

// the two ROM banks at the top of the 24-bit address space
// bank FE reads the FE image and bank FF the system image
`define IIGS_ROM1_BANK 8'hFE
`define IIGS_ROM2_BANK 8'hFF

// data returned when nothing answers the access
// this mimics the bus holding its last high bit
`define IIGS_FLOAT_DATA 8'h80

`endif
